// File: hw/asg_mem_pkg.sv
package asg_mem_pkg;

  ////////////////////
  // waveform table
  ////////////////////

  // address width, 64 samples
  // also the integer part of the phase pointer
  localparam int TBL_AW = 6;

  // sample width
  localparam int SMP_W = 16;

  ////////////////////
  // cpu port
  ////////////////////

  // byte address, word index from bit 2 up
  localparam int BUS_AW = 8;

  // access decoded from the strobes
  typedef enum logic [1:0] {
    BUS_NOP = 2'd0,
    BUS_RD  = 2'd1,
    BUS_WR  = 2'd2
  } bus_op_e;

endpackage

// File: hw/asg_ctl_pkg.sv
package asg_ctl_pkg;

  import asg_mem_pkg::*;

  ////////////////////
  // periodic pointer
  ////////////////////

  // fraction bits of the fixed point pointer
  localparam int PTR_FW = 4;

  // full pointer, integer part indexes the table
  localparam int PTR_W = TBL_AW + PTR_FW;

  ////////////////////
  // burst counters
  ////////////////////

  // period length counter
  localparam int BLN_W = 16;

  // repetition counter
  localparam int BNM_W = 8;

  // sequencer states
  typedef enum logic [1:0] {
    ST_STOP  = 2'd0,
    ST_ARMED = 2'd1,
    ST_RUN   = 2'd2
  } seq_state_e;

endpackage

// File: hw/asg_seq.sv
`timescale 1ns/10ps

module asg_seq
  import asg_mem_pkg::*;
  import asg_ctl_pkg::*;
(
  input  logic              sto,
  input  logic              ctl_rst,
  // control pulses
  input  logic              ctl_str,
  input  logic              ctl_stp,
  input  logic              ctl_trg,
  // stall from the output stage
  input  logic              adv,
  // periodic mode
  input  logic [PTR_W-1:0]  cfg_siz,
  input  logic [PTR_W-1:0]  cfg_ste,
  input  logic [PTR_W-1:0]  cfg_off,
  // burst mode
  input  logic              cfg_ben,
  input  logic              cfg_inf,
  input  logic [TBL_AW-1:0] cfg_bdl,
  input  logic [BLN_W-1:0]  cfg_bpl,
  input  logic [BNM_W-1:0]  cfg_bnm,
  // status and events
  output logic              sts_str,
  output logic              sts_stp,
  output logic              sts_trg,
  output logic              evn_per,
  output logic [BLN_W-1:0]  sts_bln,
  output logic [BNM_W-1:0]  sts_bnm,
  // table read request
  output logic [TBL_AW-1:0] rd_addr,
  output logic              rd_en,
  output logic              rd_lst
);

  seq_state_e        state;
  seq_state_e        state_nxt;
  logic              run_go;
  logic              run_adv;
  logic              run_end;
  logic              bst_end;
  logic              end_bpl;
  logic              end_bnm;
  logic              bln_dat;
  logic [PTR_W-1:0]  ptr;
  logic [PTR_W+1:0]  ptr_add;
  logic [PTR_W+1:0]  ptr_sub;
  logic [TBL_AW-1:0] adr_per;
  logic [TBL_AW-1:0] adr_bst;

  ////////////////////
  // state machine
  ////////////////////

  // a word is issued in every run cycle the pipeline moves
  assign run_adv = (state == ST_RUN) & adv;

  // final period done and no infinite repeat
  assign bst_end = cfg_ben & end_bpl & end_bnm;

  // stop acts at once, burst end only on an issued word
  assign run_end = ctl_stp | (run_adv & bst_end);

  always_comb begin
    state_nxt = state;
    case (state)
      ST_STOP: begin
        // trigger together with start skips the armed state
        if (ctl_str && !ctl_stp) begin
          state_nxt = ctl_trg ? ST_RUN : ST_ARMED;
        end
      end
      ST_ARMED: begin
        if (ctl_stp) begin
          state_nxt = ST_STOP;
        end else if (ctl_trg) begin
          state_nxt = ST_RUN;
        end
      end
      ST_RUN: begin
        // further triggers ignored while running
        if (run_end) begin
          state_nxt = ST_STOP;
        end
      end
      default: begin
        state_nxt = ST_STOP;
      end
    endcase
  end

  // entering run, pointer and counters restart
  assign run_go = (state != ST_RUN) & (state_nxt == ST_RUN);

  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      state <= ST_STOP;
    end else begin
      state <= state_nxt;
    end
  end

  assign sts_str = (state != ST_STOP);
  assign sts_stp = ~sts_str;
  assign sts_trg = (state == ST_RUN);

  ////////////////////
  // periodic pointer
  ////////////////////

  // two spare bits, top one is the sign of the wrap test
  assign ptr_add = (PTR_W+2)'(ptr) + (PTR_W+2)'(cfg_ste) + (PTR_W+2)'(1);
  assign ptr_sub = ptr_add - (PTR_W+2)'(cfg_siz) - (PTR_W+2)'(1);

  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      ptr <= '0;
    end else if (run_go) begin
      ptr <= cfg_off;
    end else if (run_adv && !cfg_ben) begin
      // modulo wrap when the difference is not negative
      ptr <= ptr_sub[PTR_W+1] ? ptr_add[PTR_W-1:0] : ptr_sub[PTR_W-1:0];
    end
  end

  // integer part only
  assign adr_per = ptr[PTR_FW +: TBL_AW];

  ////////////////////
  // burst counters
  ////////////////////

  assign end_bpl = (sts_bln == cfg_bpl);
  assign end_bnm = ~cfg_inf & (sts_bnm == cfg_bnm);

  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      sts_bln <= '0;
      sts_bnm <= '0;
    end else if (run_go) begin
      sts_bln <= '0;
      sts_bnm <= '0;
    end else if (run_adv && cfg_ben) begin
      sts_bln <= end_bpl ? '0 : sts_bln + 1'b1;
      // wraps freely in infinite mode
      sts_bnm <= sts_bnm + BNM_W'(end_bpl);
    end
  end

  // data part of the period, then hold on the last data word
  assign bln_dat = (sts_bln <= BLN_W'(cfg_bdl));
  assign adr_bst = bln_dat ? sts_bln[TBL_AW-1:0] : cfg_bdl;

  // one cycle after the final word of each period
  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      evn_per <= 1'b0;
    end else begin
      evn_per <= run_adv & cfg_ben & end_bpl;
    end
  end

  ////////////////////
  // read request
  ////////////////////

  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      rd_en  <= 1'b0;
      rd_lst <= 1'b0;
    end else if (adv) begin
      rd_en  <= (state == ST_RUN);
      // word issued in the stop cycle or at burst end
      rd_lst <= (state == ST_RUN) & run_end;
    end
  end

  always_ff @(posedge sto) begin
    if (run_adv) begin
      rd_addr <= cfg_ben ? adr_bst : adr_per;
    end
  end

endmodule

// File: hw/asg_table.sv
`timescale 1ns/10ps

module asg_table
  import asg_mem_pkg::*;
(
  input  logic              sto,
  input  logic              ctl_rst,
  // cpu port
  input  logic              bus_wen,
  input  logic              bus_ren,
  input  logic [BUS_AW-1:0] bus_addr,
  input  logic [SMP_W-1:0]  bus_wdata,
  output logic [SMP_W-1:0]  bus_rdata,
  output logic              bus_ack,
  // stream side
  input  logic              adv,
  input  logic              rd_en,
  input  logic              rd_lst,
  input  logic [TBL_AW-1:0] rd_addr,
  output logic [SMP_W-1:0]  rd_data,
  output logic              tbl_vld,
  output logic              tbl_lst
);

  logic [SMP_W-1:0]  mem [0:2**TBL_AW-1];
  bus_op_e           bus_op;
  logic [TBL_AW-1:0] bus_idx;

  ////////////////////
  // cpu access
  ////////////////////

  // word index, byte lane bits dropped
  assign bus_idx = bus_addr[2 +: TBL_AW];

  // write wins when both strobes are high
  always_comb begin
    if (bus_wen) begin
      bus_op = BUS_WR;
    end else if (bus_ren) begin
      bus_op = BUS_RD;
    end else begin
      bus_op = BUS_NOP;
    end
  end

  always_ff @(posedge sto) begin
    case (bus_op)
      BUS_WR: begin
        mem[bus_idx] <= bus_wdata;
      end
      BUS_RD: begin
        bus_rdata <= mem[bus_idx];
      end
      default: begin
      end
    endcase
  end

  // ack one cycle after either strobe, rdata valid with it
  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      bus_ack <= 1'b0;
    end else begin
      bus_ack <= (bus_op != BUS_NOP);
    end
  end

  ////////////////////
  // stream read
  ////////////////////

  // read register holds its value on gaps and stalls
  always_ff @(posedge sto) begin
    if (adv && rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

  // valid and last follow the data one stage on
  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      tbl_vld <= 1'b0;
      tbl_lst <= 1'b0;
    end else if (adv) begin
      tbl_vld <= rd_en;
      tbl_lst <= rd_en & rd_lst;
    end
  end

endmodule

// File: hw/asg_out.sv
`timescale 1ns/10ps

module asg_out
  import asg_mem_pkg::*;
(
  input  logic             sto,
  input  logic             ctl_rst,
  // from the table
  input  logic [SMP_W-1:0] rd_data,
  input  logic             tbl_vld,
  input  logic             tbl_lst,
  // stream
  input  logic             str_ready,
  output logic [SMP_W-1:0] str_data,
  output logic             str_valid,
  output logic             str_last,
  // event and stall
  output logic             evn_lst,
  output logic             adv
);

  ////////////////////
  // stall condition
  ////////////////////

  // output register empty or being taken
  // every upstream stage moves only with this
  assign adv = str_ready | ~str_valid;

  ////////////////////
  // output register
  ////////////////////

  always_ff @(posedge sto) begin
    if (ctl_rst) begin
      str_valid <= 1'b0;
      str_last  <= 1'b0;
    end else if (adv) begin
      str_valid <= tbl_vld;
      // last only meaningful with valid
      str_last  <= tbl_vld & tbl_lst;
    end
  end

  // payload loads only with a valid word
  // so it stays stable under back-pressure
  always_ff @(posedge sto) begin
    if (adv && tbl_vld) begin
      str_data <= rd_data;
    end
  end

  ////////////////////
  // last word event
  ////////////////////

  // one cycle, on the transfer of the final word
  assign evn_lst = str_valid & str_last & str_ready;

endmodule

// File: hw/asg_top.sv
`timescale 1ns/10ps

module asg_top
  import asg_mem_pkg::*;
  import asg_ctl_pkg::*;
(
  input  logic              sto,
  input  logic              ctl_rst,
  // control and status
  input  logic              ctl_str,
  input  logic              ctl_stp,
  input  logic              ctl_trg,
  output logic              sts_str,
  output logic              sts_stp,
  output logic              sts_trg,
  // events
  output logic              evn_per,
  output logic              evn_lst,
  // periodic mode
  input  logic [PTR_W-1:0]  cfg_siz,
  input  logic [PTR_W-1:0]  cfg_ste,
  input  logic [PTR_W-1:0]  cfg_off,
  // burst mode
  input  logic              cfg_ben,
  input  logic              cfg_inf,
  input  logic [TBL_AW-1:0] cfg_bdl,
  input  logic [BLN_W-1:0]  cfg_bpl,
  input  logic [BNM_W-1:0]  cfg_bnm,
  // burst status
  output logic [BLN_W-1:0]  sts_bln,
  output logic [BNM_W-1:0]  sts_bnm,
  // cpu port
  input  logic              bus_wen,
  input  logic              bus_ren,
  input  logic [BUS_AW-1:0] bus_addr,
  input  logic [SMP_W-1:0]  bus_wdata,
  output logic [SMP_W-1:0]  bus_rdata,
  output logic              bus_ack,
  // output stream
  output logic [SMP_W-1:0]  str_data,
  output logic              str_valid,
  output logic              str_last,
  input  logic              str_ready
);

  ////////////////////
  // internal links
  ////////////////////

  // single stall condition, from the output stage
  logic              adv;
  // sequencer to table
  logic [TBL_AW-1:0] rd_addr;
  logic              rd_en;
  logic              rd_lst;
  // table to output stage
  logic [SMP_W-1:0]  rd_data;
  logic              tbl_vld;
  logic              tbl_lst;

  // address producer
  asg_seq i_asg_seq (
    .sto     (sto),
    .ctl_rst (ctl_rst),
    .ctl_str (ctl_str),
    .ctl_stp (ctl_stp),
    .ctl_trg (ctl_trg),
    .adv     (adv),
    .cfg_siz (cfg_siz),
    .cfg_ste (cfg_ste),
    .cfg_off (cfg_off),
    .cfg_ben (cfg_ben),
    .cfg_inf (cfg_inf),
    .cfg_bdl (cfg_bdl),
    .cfg_bpl (cfg_bpl),
    .cfg_bnm (cfg_bnm),
    .sts_str (sts_str),
    .sts_stp (sts_stp),
    .sts_trg (sts_trg),
    .evn_per (evn_per),
    .sts_bln (sts_bln),
    .sts_bnm (sts_bnm),
    .rd_addr (rd_addr),
    .rd_en   (rd_en),
    .rd_lst  (rd_lst)
  );

  // waveform memory
  asg_table i_asg_table (
    .sto       (sto),
    .ctl_rst   (ctl_rst),
    .bus_wen   (bus_wen),
    .bus_ren   (bus_ren),
    .bus_addr  (bus_addr),
    .bus_wdata (bus_wdata),
    .bus_rdata (bus_rdata),
    .bus_ack   (bus_ack),
    .adv       (adv),
    .rd_en     (rd_en),
    .rd_lst    (rd_lst),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data),
    .tbl_vld   (tbl_vld),
    .tbl_lst   (tbl_lst)
  );

  // stream register
  asg_out i_asg_out (
    .sto       (sto),
    .ctl_rst   (ctl_rst),
    .rd_data   (rd_data),
    .tbl_vld   (tbl_vld),
    .tbl_lst   (tbl_lst),
    .str_ready (str_ready),
    .str_data  (str_data),
    .str_valid (str_valid),
    .str_last  (str_last),
    .evn_lst   (evn_lst),
    .adv       (adv)
  );

endmodule

// File: bench/asg_chk.sv
`timescale 1ns/10ps

module asg_chk
  import asg_mem_pkg::*;
(
  input logic             sto,
  input logic             ctl_rst,
  input logic             bus_wen,
  input logic             bus_ren,
  input logic             bus_ack,
  input logic             sts_str,
  input logic             sts_stp,
  input logic             evn_lst,
  input logic [SMP_W-1:0] str_data,
  input logic             str_valid,
  input logic             str_last,
  input logic             str_ready
);

  bus_op_e bus_op;

  // same decode as the cpu port
  assign bus_op = bus_wen ? BUS_WR : (bus_ren ? BUS_RD : BUS_NOP);

  ////////////////////
  // stream
  ////////////////////

  // stalled word stays put until taken
  a_hold: assert property (@(posedge sto) disable iff (ctl_rst)
    (str_valid && !str_ready) |=> (str_valid && $stable(str_data) && $stable(str_last)))
    else $error("stream word changed while stalled");

  // last word event only on a valid last word
  a_lst: assert property (@(posedge sto) disable iff (ctl_rst)
    evn_lst |-> (str_valid && str_last))
    else $error("evn_lst without a valid last word");

  ////////////////////
  // status and cpu
  ////////////////////

  a_stp: assert property (@(posedge sto) sts_stp == !sts_str)
    else $error("sts_stp is not the inverse of sts_str");

  // ack exactly one cycle after a strobe
  a_ack: assert property (@(posedge sto) disable iff (ctl_rst)
    bus_ack == $past(bus_op != BUS_NOP))
    else $error("bus_ack not one cycle after a strobe");

endmodule

bind asg_top asg_chk i_asg_chk (
  .sto       (sto),
  .ctl_rst   (ctl_rst),
  .bus_wen   (bus_wen),
  .bus_ren   (bus_ren),
  .bus_ack   (bus_ack),
  .sts_str   (sts_str),
  .sts_stp   (sts_stp),
  .evn_lst   (evn_lst),
  .str_data  (str_data),
  .str_valid (str_valid),
  .str_last  (str_last),
  .str_ready (str_ready)
);

// File: bench/asg_tb.sv
`timescale 1ns/10ps

module asg_tb
  import asg_mem_pkg::*;
  import asg_ctl_pkg::*;
();

  // cycles allowed for any single wait
  localparam int WAIT_MAX = 4000;
  // periodic: 40 samples per cycle, step 1.5, start at 5.5
  localparam int P_SIZ = 40 * (2**PTR_FW) - 1;
  localparam int P_STE = 3 * (2**PTR_FW) / 2 - 1;
  localparam int P_OFF = 11 * (2**PTR_FW) / 2;
  // burst: 10 data words, 15 per period, 3 periods
  localparam int B_BDL = 9;
  localparam int B_BPL = 14;
  localparam int B_BNM = 2;

  logic              sto = 1'b0;
  logic              ctl_rst;
  logic              ctl_str;
  logic              ctl_stp;
  logic              ctl_trg;
  logic              sts_str;
  logic              sts_stp;
  logic              sts_trg;
  logic              evn_per;
  logic              evn_lst;
  logic [PTR_W-1:0]  cfg_siz;
  logic [PTR_W-1:0]  cfg_ste;
  logic [PTR_W-1:0]  cfg_off;
  logic              cfg_ben;
  logic              cfg_inf;
  logic [TBL_AW-1:0] cfg_bdl;
  logic [BLN_W-1:0]  cfg_bpl;
  logic [BNM_W-1:0]  cfg_bnm;
  logic [BLN_W-1:0]  sts_bln;
  logic [BNM_W-1:0]  sts_bnm;
  logic              bus_wen;
  logic              bus_ren;
  logic [BUS_AW-1:0] bus_addr;
  logic [SMP_W-1:0]  bus_wdata;
  logic [SMP_W-1:0]  bus_rdata;
  logic              bus_ack;
  logic [SMP_W-1:0]  str_data;
  logic              str_valid;
  logic              str_last;
  logic              str_ready = 1'b1;

  // table as written over the cpu port
  logic [SMP_W-1:0] tbl_ref [0:2**TBL_AW-1];
  // model address stream
  int               exp_addr [$];
  // accepted words, kept for the whole run
  logic [SMP_W-1:0] rx_data [$];
  bit               rx_last [$];
  int               n_per = 0;
  int               n_lst = 0;
  // start of the current test in the logs
  int               rx_base;
  int               per_base;
  int               lst_base;
  int               n_err = 0;
  int               n_chk = 0;
  integer           seed = 45535;
  bit               rand_rdy = 1'b0;

  always #2 sto = ~sto;

  asg_top i_asg_top (
    .sto(sto), .ctl_rst(ctl_rst),
    .ctl_str(ctl_str), .ctl_stp(ctl_stp), .ctl_trg(ctl_trg),
    .sts_str(sts_str), .sts_stp(sts_stp), .sts_trg(sts_trg),
    .evn_per(evn_per), .evn_lst(evn_lst),
    .cfg_siz(cfg_siz), .cfg_ste(cfg_ste), .cfg_off(cfg_off),
    .cfg_ben(cfg_ben), .cfg_inf(cfg_inf), .cfg_bdl(cfg_bdl),
    .cfg_bpl(cfg_bpl), .cfg_bnm(cfg_bnm),
    .sts_bln(sts_bln), .sts_bnm(sts_bnm),
    .bus_wen(bus_wen), .bus_ren(bus_ren), .bus_addr(bus_addr),
    .bus_wdata(bus_wdata), .bus_rdata(bus_rdata), .bus_ack(bus_ack),
    .str_data(str_data), .str_valid(str_valid), .str_last(str_last),
    .str_ready(str_ready)
  );

  ////////////////////
  // monitor and sink
  ////////////////////

  // transfers and events as seen at the edge
  always @(posedge sto) begin
    if (str_valid && str_ready) begin
      rx_data.push_back(str_data);
      rx_last.push_back(str_last);
    end
    if (evn_per) begin
      n_per++;
    end
    if (evn_lst) begin
      n_lst++;
    end
  end

  // back-pressure, full speed unless randomized
  always @(posedge sto) begin
    if (rand_rdy) begin
      str_ready <= 1'($random(seed));
    end else begin
      str_ready <= 1'b1;
    end
  end

  ////////////////////
  // helpers
  ////////////////////

  task automatic check_eq(input int got, input int exp, input string msg);
    n_chk++;
    if (got != exp) begin
      n_err++;
      $display("CHECK FAILED at %0t: %s, got 0x%0h, expected 0x%0h", $time, msg, got, exp);
    end
  endtask

  function automatic int rx_count();
    return rx_data.size() - rx_base;
  endfunction

  task automatic mark_rx();
    rx_base  = rx_data.size();
    per_base = n_per;
    lst_base = n_lst;
  endtask

  // one cycle of control pulses
  task automatic pulse_ctl(input logic str, input logic stp, input logic trg);
    @(posedge sto);
    ctl_str <= str;
    ctl_stp <= stp;
    ctl_trg <= trg;
    @(posedge sto);
    ctl_str <= 1'b0;
    ctl_stp <= 1'b0;
    ctl_trg <= 1'b0;
  endtask

  task automatic wait_words(input int n, input string tag);
    int cyc;
    cyc = 0;
    while (rx_count() < n && cyc < WAIT_MAX) begin
      @(negedge sto);
      cyc++;
    end
    if (rx_count() < n) begin
      n_err++;
      $display("%s: timed out with %0d of %0d words received", tag, rx_count(), n);
    end
  endtask

  task automatic wait_idle(input string tag);
    int cyc;
    cyc = 0;
    @(negedge sto);
    while (str_valid && cyc < WAIT_MAX) begin
      @(negedge sto);
      cyc++;
    end
    if (str_valid) begin
      n_err++;
      $display("%s: timed out waiting for the stream to go idle", tag);
    end
  endtask

  task automatic wait_last(input string tag);
    int cyc;
    cyc = 0;
    while (n_lst == lst_base && cyc < WAIT_MAX) begin
      @(negedge sto);
      cyc++;
    end
    if (n_lst == lst_base) begin
      n_err++;
      $display("%s: timed out waiting for the last word", tag);
    end
  endtask

  ////////////////////
  // reference model
  ////////////////////

  // fixed point pointer, modulo wrap at size+1
  task automatic build_periodic(input int n);
    int p;
    exp_addr.delete();
    p = P_OFF;
    for (int i = 0; i < n; i++) begin
      exp_addr.push_back(p / (2**PTR_FW));
      p = p + P_STE + 1;
      if (p >= P_SIZ + 1) begin
        p = p - P_SIZ - 1;
      end
    end
  endtask

  // data words then hold on the last one
  task automatic build_burst(input int nper);
    exp_addr.delete();
    for (int k = 0; k < nper; k++) begin
      for (int j = 0; j <= B_BPL; j++) begin
        exp_addr.push_back((j <= B_BDL) ? j : B_BDL);
      end
    end
  endtask

  // exact compares the word count too
  // fin_lst is the expected last flag of the final word received
  task automatic compare_words(input string tag, input bit exact, input bit fin_lst);
    int n;
    int lst;
    n = rx_count();
    if (exact) begin
      check_eq(n, exp_addr.size(), {tag, " word count"});
    end else begin
      check_eq(int'(n <= exp_addr.size()), 1, {tag, " more words than model"});
    end
    for (int i = 0; i < n && i < exp_addr.size(); i++) begin
      check_eq(rx_data[rx_base + i], tbl_ref[exp_addr[i]], $sformatf("%s word %0d", tag, i));
      lst = (i == n - 1) ? int'(fin_lst) : 0;
      check_eq(rx_last[rx_base + i], lst, $sformatf("%s last flag %0d", tag, i));
    end
  endtask

  ////////////////////
  // tests
  ////////////////////

  task automatic bus_access(input logic wr, input int idx, input logic [SMP_W-1:0] val);
    @(posedge sto);
    bus_wen   <= wr;
    bus_ren   <= ~wr;
    bus_addr  <= BUS_AW'(idx * 4);
    bus_wdata <= val;
    @(posedge sto);
    bus_wen <= 1'b0;
    bus_ren <= 1'b0;
    check_eq(bus_ack, 0, $sformatf("bus_ack early at index %0d", idx));
    @(posedge sto);
    check_eq(bus_ack, 1, $sformatf("bus_ack at index %0d", idx));
    if (!wr) begin
      check_eq(bus_rdata, tbl_ref[idx], $sformatf("bus_rdata at index %0d", idx));
    end
  endtask

  task automatic test_cpu();
    for (int i = 0; i < 2**TBL_AW; i++) begin
      tbl_ref[i] = SMP_W'(i * 257 + 64);
      bus_access(1'b1, i, tbl_ref[i]);
    end
    for (int i = 0; i < 2**TBL_AW; i++) begin
      bus_access(1'b0, i, '0);
    end
  endtask

  task automatic run_periodic(input string tag);
    int seen;
    bit rdy_keep;
    seen = 0;
    build_periodic(300);
    mark_rx();
    @(posedge sto);
    cfg_ben <= 1'b0;
    cfg_inf <= 1'b0;
    cfg_siz <= PTR_W'(P_SIZ);
    cfg_ste <= PTR_W'(P_STE);
    cfg_off <= PTR_W'(P_OFF);
    pulse_ctl(1'b1, 1'b0, 1'b0);
    pulse_ctl(1'b0, 1'b0, 1'b1);
    wait_words(100, tag);
    // full speed over the stop, so the stop cycle issues the last word
    rdy_keep = rand_rdy;
    rand_rdy = 1'b0;
    pulse_ctl(1'b0, 1'b1, 1'b0);
    @(negedge sto);
    rand_rdy = rdy_keep;
    wait_idle(tag);
    check_eq(sts_str, 0, {tag, " sts_str after stop"});
    // no more words once drained
    repeat (20) begin
      @(negedge sto);
      seen += int'(str_valid);
    end
    check_eq(seen, 0, {tag, " str_valid after stop"});
    compare_words(tag, 1'b0, 1'b1);
  endtask

  task automatic run_burst(input string tag);
    build_burst(B_BNM + 1);
    mark_rx();
    @(posedge sto);
    cfg_ben <= 1'b1;
    cfg_inf <= 1'b0;
    cfg_bdl <= TBL_AW'(B_BDL);
    cfg_bpl <= BLN_W'(B_BPL);
    cfg_bnm <= BNM_W'(B_BNM);
    pulse_ctl(1'b1, 1'b0, 1'b0);
    pulse_ctl(1'b0, 1'b0, 1'b1);
    wait_last(tag);
    wait_idle(tag);
    compare_words(tag, 1'b1, 1'b1);
    check_eq(n_per - per_base, B_BNM + 1, {tag, " evn_per count"});
    check_eq(n_lst - lst_base, 1, {tag, " evn_lst count"});
    check_eq(sts_trg, 0, {tag, " sts_trg at end"});
  endtask

  task automatic test_trigger();
    mark_rx();
    @(posedge sto);
    cfg_ben <= 1'b1;
    cfg_inf <= 1'b1;
    cfg_bdl <= TBL_AW'(B_BDL);
    cfg_bpl <= BLN_W'(B_BPL);
    // trigger alone, observed over a fixed window
    pulse_ctl(1'b0, 1'b0, 1'b1);
    repeat (12) @(negedge sto);
    check_eq(rx_count(), 0, "words after lone trigger");
    check_eq(sts_str, 0, "sts_str after lone trigger");
    check_eq(sts_trg, 0, "sts_trg after lone trigger");
    // start and trigger together
    build_burst(4);
    pulse_ctl(1'b1, 1'b0, 1'b1);
    wait_words(20, "start with trigger");
    check_eq(sts_str, 1, "sts_str while running");
    check_eq(sts_trg, 1, "sts_trg while running");
    check_eq(int'(sts_bnm != '0), 1, "sts_bnm counting");
    compare_words("start with trigger", 1'b0, 1'b0);
    // reset mid-run
    @(posedge sto);
    ctl_rst <= 1'b1;
    @(posedge sto);
    ctl_rst <= 1'b0;
    @(negedge sto);
    check_eq(sts_str, 0, "sts_str after reset");
    check_eq(sts_trg, 0, "sts_trg after reset");
    check_eq(sts_bln, 0, "sts_bln after reset");
    check_eq(sts_bnm, 0, "sts_bnm after reset");
    check_eq(str_valid, 0, "str_valid after reset");
    @(posedge sto);
    cfg_inf <= 1'b0;
  endtask

  initial begin
    ctl_rst   = 1'b1;
    ctl_str   = 1'b0;
    ctl_stp   = 1'b0;
    ctl_trg   = 1'b0;
    cfg_siz   = '0;
    cfg_ste   = '0;
    cfg_off   = '0;
    cfg_ben   = 1'b0;
    cfg_inf   = 1'b0;
    cfg_bdl   = '0;
    cfg_bpl   = '0;
    cfg_bnm   = '0;
    bus_wen   = 1'b0;
    bus_ren   = 1'b0;
    bus_addr  = '0;
    bus_wdata = '0;
    repeat (3) @(posedge sto);
    ctl_rst <= 1'b0;

    test_cpu();
    run_periodic("periodic");
    test_trigger();
    run_burst("burst");
    // same streams under random back-pressure
    rand_rdy = 1'b1;
    run_periodic("periodic random ready");
    run_burst("burst random ready");
    rand_rdy = 1'b0;
    repeat (4) @(posedge sto);

    $display("checks: %0d, errors: %0d", n_chk, n_err);
    if (n_err == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// File: filelist.f
hw/asg_mem_pkg.sv
hw/asg_ctl_pkg.sv
hw/asg_seq.sv
hw/asg_table.sv
hw/asg_out.sv
hw/asg_top.sv
bench/asg_chk.sv
bench/asg_tb.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := asg_tb
RTL_TOP    := asg_top
FILELIST   := filelist.f
OBJ_DIR    := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert -Wno-fatal -j 0
LINT_FLAGS := --lint-only -Wall --timing
FAIL_MSG   := *** FAILED ***
PASS_MSG   := *** PASSED ***

SOURCES := $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -qF "$(PASS_MSG)" $(LOG); then echo "simulation ended without a result"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
